/* verilog/mc1201_config.svh */
// MC1201 bus fabric build parameters for widths, counts and I/O window bases
`ifndef MC1201_CONFIG_SVH
`define MC1201_CONFIG_SVH

`default_nettype none

//************************************************************
//* bus geometry
//************************************************************
`define ADDR_WIDTH 17   // 16-bit address plus console mode bit
`define DATA_WIDTH 16

`define DMA_MASTERS 2   // RK11 first then MY
`define SD_PORTS    4   // RK DW DX MY

//************************************************************
//* I/O page windows (octal base and lowest compared bit)
//************************************************************
`define UART1_BASE 17'o177560  // console UART 177560-177566
`define UART1_LSB  3
`define UART2_BASE 17'o176500  // second UART 176500-176506
`define UART2_LSB  3
`define LPT_BASE   17'o177514  // printer 177514-177516
`define LPT_LSB    2
`define RK_BASE    17'o177400  // RK11 177400-177416
`define RK_LSB     4
`define DW_BASE    17'o174000  // DW 174000-174036
`define DW_LSB     5
`define DX_BASE    17'o177170  // DX 177170-177172
`define DX_LSB     2
`define MY_BASE    17'o172140  // MY 172140-172142
`define MY_LSB     2
`define KGD_BASE   17'o176640  // graphics 176640-176646
`define KGD_LSB    3

// shadow monitor ROM sits where bits 16..13 read 1110
`define ROM_TAG    4'b1110

`default_nettype wire

`endif

/* verilog/wb_pkg.sv */
// Wishbone types shared by every master and slave port of the fabric
`include "mc1201_config.svh"

`default_nettype none

package wb_pkg;

	//************************************************************
	//* master side
	//************************************************************
	typedef struct packed {
		logic [`ADDR_WIDTH-1:0] adr;  // bit 16 marks console space
		logic [`DATA_WIDTH-1:0] dat;  // write data
		logic                   cyc;  // cycle open
		logic                   we;   // 1 = write
		logic [1:0]             sel;  // high and low byte enables
		logic                   stb;  // transfer strobe
	} wb_req_t;

	//************************************************************
	//* slave side
	//************************************************************
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] dat;  // read data
		logic                   ack;  // transfer done
	} wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/board_pkg.sv */
// Board level types for device selection and SD-card line bundles
`default_nettype none

package board_pkg;

	// device slots on the system bus
	// order here sets the bit position in every select vector
	typedef enum logic [3:0] {
		DEV_UART1 = 4'd0,  // console serial port
		DEV_UART2 = 4'd1,  // second serial port
		DEV_LPT   = 4'd2,  // parallel printer
		DEV_RK    = 4'd3,  // RK11 disk registers
		DEV_DW    = 4'd4,  // DW hard disk registers
		DEV_DX    = 4'd5,  // RX01 floppy registers
		DEV_MY    = 4'd6,  // MY floppy registers
		DEV_KGD   = 4'd7,  // graphics card
		DEV_ROM   = 4'd8,  // shadow monitor ROM
		DEV_DRAM  = 4'd9   // main memory
	} dev_idx_e;

	localparam int unsigned DEV_NUM = int'(DEV_DRAM) + 1;

	// one bit per device, at most one set
	typedef logic [DEV_NUM-1:0] dev_sel_t;

	// what each disk controller wants on the card pins
	typedef struct packed {
		logic cs;    // chip select
		logic mosi;  // serial data to card
	} sd_lines_t;

endpackage

`default_nettype wire

/* verilog/bus_master_arbiter.sv */
// Bus master arbiter switching the shared Wishbone bus between CPU and DMA masters
`include "mc1201_config.svh"

`default_nettype none

module bus_master_arbiter (
	input  wire logic             wb_clk,
	input  wire logic             rst_i,
	input  wire wb_pkg::wb_req_t  cpu_req_i,
	input  wire wb_pkg::wb_req_t  dma_req_i [`DMA_MASTERS],  // cyc doubles as request
	input  wire wb_pkg::wb_rsp_t  bus_rsp_i,                 // merged slave response
	output wb_pkg::wb_req_t       bus_o,
	output wb_pkg::wb_rsp_t       cpu_rsp_o,
	output wb_pkg::wb_rsp_t       dma_rsp_o [`DMA_MASTERS],
	output logic                  cpu_gnt_o,
	output logic [`DMA_MASTERS-1:0] dma_gnt_o
);

	import wb_pkg::*;

	localparam wb_rsp_t RSP_IDLE = '{dat: '0, ack: 1'b0};  // what a parked master sees

	logic [`DMA_MASTERS-1:0] dma_pick;  // next owner among DMA masters

	//************************************************************
	//* priority pick
	//************************************************************
	// walk from the top so the lowest index overrides
	always_comb begin
		dma_pick = '0;
		for (int i = `DMA_MASTERS - 1; i >= 0; i--) begin
			if (dma_req_i[i].cyc) begin
				dma_pick    = '0;
				dma_pick[i] = 1'b1;
			end
		end
	end

	// grant register only moves while the bus is idle
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			dma_gnt_o <= '0;             // CPU owns bus after reset
		end else if (!bus_o.cyc) begin
			dma_gnt_o <= dma_pick;       // empty pick hands bus back to CPU
		end
	end

	assign cpu_gnt_o = ~|dma_gnt_o;

	//************************************************************
	//* master to bus mux
	//************************************************************
	always_comb begin
		bus_o = cpu_req_i;  // default owner
		for (int i = 0; i < `DMA_MASTERS; i++) begin
			if (dma_gnt_o[i]) begin
				bus_o     = dma_req_i[i];
				bus_o.adr = {1'b0, dma_req_i[i].adr[`ADDR_WIDTH-2:0]};  // DMA sees user space only
				bus_o.sel = 2'b11;  // DMA always moves whole words
			end
		end
	end

	// response goes back to the owner only
	always_comb begin
		cpu_rsp_o = cpu_gnt_o ? bus_rsp_i : RSP_IDLE;
		for (int i = 0; i < `DMA_MASTERS; i++) begin
			dma_rsp_o[i] = dma_gnt_o[i] ? bus_rsp_i : RSP_IDLE;
		end
	end

endmodule

`default_nettype wire

/* verilog/io_page_decoder.sv */
// Address decoder producing one device strobe per bus transfer
`include "mc1201_config.svh"

`default_nettype none

module io_page_decoder (
	input  wire wb_pkg::wb_req_t bus_i,
	output board_pkg::dev_sel_t  dev_stb_o
);

	import board_pkg::*;

	dev_sel_t hit;      // raw address match per device
	logic     bus_act;  // a transfer is on the bus

	// compare the address above lsb with the window base
	function automatic logic win_hit(
		input logic [`ADDR_WIDTH-1:0] adr,
		input logic [`ADDR_WIDTH-1:0] base,
		input int unsigned            lsb
	);
		return (adr >> lsb) == (base >> lsb);
	endfunction

	//************************************************************
	//* window match
	//************************************************************
	always_comb begin
		// I/O page registers
		hit[DEV_UART1] = win_hit(bus_i.adr, `UART1_BASE, `UART1_LSB);
		hit[DEV_UART2] = win_hit(bus_i.adr, `UART2_BASE, `UART2_LSB);
		hit[DEV_LPT]   = win_hit(bus_i.adr, `LPT_BASE, `LPT_LSB);
		hit[DEV_RK]    = win_hit(bus_i.adr, `RK_BASE, `RK_LSB);
		hit[DEV_DW]    = win_hit(bus_i.adr, `DW_BASE, `DW_LSB);
		hit[DEV_DX]    = win_hit(bus_i.adr, `DX_BASE, `DX_LSB);
		hit[DEV_MY]    = win_hit(bus_i.adr, `MY_BASE, `MY_LSB);
		hit[DEV_KGD]   = win_hit(bus_i.adr, `KGD_BASE, `KGD_LSB);

		// monitor ROM in the shadow space
		hit[DEV_ROM] = bus_i.adr[`ADDR_WIDTH-1:`ADDR_WIDTH-4] == `ROM_TAG;

		// user mode gets 000000-157776
		// console mode flips to 160000-177776
		hit[DEV_DRAM] = (bus_i.adr[`ADDR_WIDTH-2:`ADDR_WIDTH-4] != 3'b111)
			^ bus_i.adr[`ADDR_WIDTH-1];
	end

	assign bus_act = bus_i.cyc & bus_i.stb;

	// no strobe outside a live transfer
	assign dev_stb_o = hit & {DEV_NUM{bus_act}};

endmodule

`default_nettype wire

/* verilog/slave_response_mux.sv */
// Slave response mux merging device acknowledges and read data for the bus
`default_nettype none

module slave_response_mux (
	input  wire board_pkg::dev_sel_t dev_stb_i,
	input  wire wb_pkg::wb_rsp_t     dev_rsp_i [board_pkg::DEV_NUM],
	output wb_pkg::wb_rsp_t          bus_rsp_o
);

	import board_pkg::*;

	//************************************************************
	//* merge
	//************************************************************
	// acks are ORed from every slave
	// data only from the strobed slave so idle slaves may drive junk
	always_comb begin
		bus_rsp_o = '0;  // nothing selected reads as zero
		for (int i = 0; i < DEV_NUM; i++) begin
			bus_rsp_o.ack = bus_rsp_o.ack | dev_rsp_i[i].ack;
			if (dev_stb_i[i]) begin
				bus_rsp_o.dat = bus_rsp_o.dat | dev_rsp_i[i].dat;  // one-hot strobe
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/sd_card_dispatcher.sv */
// SD-card dispatcher granting the single card to one disk controller at a time
`include "mc1201_config.svh"

`default_nettype none

module sd_card_dispatcher (
	input  wire logic                 wb_clk,
	input  wire logic                 rst_i,
	input  wire logic [`SD_PORTS-1:0] sd_req_i,                // RK DW DX MY
	input  wire board_pkg::sd_lines_t sd_lines_i [`SD_PORTS],
	output logic [`SD_PORTS-1:0]      sd_ack_o,                // one-hot owner
	output logic                      sdcard_cs_o,
	output logic                      sdcard_mosi_o
);

	import board_pkg::*;

	logic                 card_idle;   // nobody owns the card
	logic [`SD_PORTS-1:0] first_req;   // lowest requesting port
	sd_lines_t            card_lines;  // lines routed to the pins

	assign card_idle = ~|sd_ack_o;

	// lowest index wins so walk from the top
	always_comb begin
		first_req = '0;
		for (int i = `SD_PORTS - 1; i >= 0; i--) begin
			if (sd_req_i[i]) begin
				first_req    = '0;
				first_req[i] = 1'b1;
			end
		end
	end

	//************************************************************
	//* ownership
	//************************************************************
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			sd_ack_o <= '0;
		end else if (card_idle) begin
			sd_ack_o <= first_req;  // search for a requester
		end else begin
			sd_ack_o <= sd_ack_o & sd_req_i;  // owner keeps card until it lets go
		end
	end

	//************************************************************
	//* card pin steering
	//************************************************************
	always_comb begin
		card_lines = sd_lines_i[0];  // RK drives the pins when idle
		for (int i = 1; i < `SD_PORTS; i++) begin
			if (sd_ack_o[i]) begin
				card_lines = sd_lines_i[i];
			end
		end
	end

	assign sdcard_cs_o   = card_lines.cs;
	assign sdcard_mosi_o = card_lines.mosi;

endmodule

`default_nettype wire

/* verilog/mc1201_fabric.sv */
// MC1201 system bus fabric joining arbiter, decoder, response mux and SD dispatcher
`include "mc1201_config.svh"

`default_nettype none

module mc1201_fabric (
	input  wire logic                 wb_clk,
	input  wire logic                 rst_i,
	// masters
	input  wire wb_pkg::wb_req_t      cpu_req_i,
	input  wire wb_pkg::wb_req_t      dma_req_i [`DMA_MASTERS],
	output wb_pkg::wb_rsp_t           cpu_rsp_o,
	output wb_pkg::wb_rsp_t           dma_rsp_o [`DMA_MASTERS],
	output logic                      cpu_gnt_o,
	output logic [`DMA_MASTERS-1:0]   dma_gnt_o,
	// slaves
	output wb_pkg::wb_req_t           bus_o,
	output board_pkg::dev_sel_t       dev_stb_o,
	input  wire wb_pkg::wb_rsp_t      dev_rsp_i [board_pkg::DEV_NUM],
	// SD card
	input  wire logic [`SD_PORTS-1:0] sd_req_i,
	input  wire board_pkg::sd_lines_t sd_lines_i [`SD_PORTS],
	output logic [`SD_PORTS-1:0]      sd_ack_o,
	output logic                      sdcard_cs_o,
	output logic                      sdcard_mosi_o
);

	import wb_pkg::*;

	wb_rsp_t bus_rsp;  // merged slave answer back to the arbiter

	//************************************************************
	//* bus path
	//************************************************************
	bus_master_arbiter i_bus_master_arbiter (
		.wb_clk    (wb_clk),
		.rst_i     (rst_i),
		.cpu_req_i (cpu_req_i),
		.dma_req_i (dma_req_i),
		.bus_rsp_i (bus_rsp),
		.bus_o     (bus_o),
		.cpu_rsp_o (cpu_rsp_o),
		.dma_rsp_o (dma_rsp_o),
		.cpu_gnt_o (cpu_gnt_o),
		.dma_gnt_o (dma_gnt_o)
	);

	io_page_decoder i_io_page_decoder (
		.bus_i     (bus_o),
		.dev_stb_o (dev_stb_o)
	);

	slave_response_mux i_slave_response_mux (
		.dev_stb_i (dev_stb_o),
		.dev_rsp_i (dev_rsp_i),
		.bus_rsp_o (bus_rsp)
	);

	//************************************************************
	//* SD card sharing
	//************************************************************
	sd_card_dispatcher i_sd_card_dispatcher (
		.wb_clk        (wb_clk),
		.rst_i         (rst_i),
		.sd_req_i      (sd_req_i),
		.sd_lines_i    (sd_lines_i),
		.sd_ack_o      (sd_ack_o),
		.sdcard_cs_o   (sdcard_cs_o),
		.sdcard_mosi_o (sdcard_mosi_o)
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Testbench clock and reset source for the bus fabric
`default_nettype none

module tb_clock (
	output logic wb_clk,
	output logic rst_i
);

	timeunit 1ns;
	timeprecision 1ns;

	localparam int unsigned HALF_PERIOD = 50;  // 100 ns period

	initial begin
		wb_clk = 1'b0;
		forever #HALF_PERIOD wb_clk = ~wb_clk;
	end

	// reset held for four rising edges
	initial begin
		rst_i = 1'b1;
		repeat (4) @(posedge wb_clk);
		rst_i <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb/tb_mc1201_fabric.sv */
// Random testbench for the MC1201 bus fabric with device, master and SD models
`include "mc1201_config.svh"

`default_nettype none

module tb_mc1201_fabric;

	timeunit 1ns;
	timeprecision 1ns;

	import wb_pkg::*;
	import board_pkg::*;

	localparam int unsigned NUM_TXN     = 600;
	localparam int unsigned CYCLE_LIMIT = NUM_TXN * 5;  // 5 cycles worst case per transfer

	logic wb_clk, rst_i;
	wb_req_t cpu_req, bus_o, exp_bus;
	wb_req_t dma_req [`DMA_MASTERS];
	wb_rsp_t cpu_rsp_o;
	wb_rsp_t dma_rsp_o [`DMA_MASTERS];
	wb_rsp_t dev_rsp [DEV_NUM];
	logic cpu_gnt_o;
	logic [`DMA_MASTERS-1:0] dma_gnt_o, model_gnt;
	dev_sel_t dev_stb_o;
	logic [`SD_PORTS-1:0] sd_req, sd_ack_o, model_own;
	sd_lines_t sd_lines [`SD_PORTS];
	logic sdcard_cs_o, sdcard_mosi_o;
	logic dev_busy [DEV_NUM];
	int unsigned dev_cnt [DEV_NUM];
	int unsigned txn_done, cycles, errors, checks;

	tb_clock i_tb_clock (.wb_clk(wb_clk), .rst_i(rst_i));

	mc1201_fabric i_mc1201_fabric (
		.wb_clk(wb_clk), .rst_i(rst_i),
		.cpu_req_i(cpu_req), .dma_req_i(dma_req),
		.cpu_rsp_o(cpu_rsp_o), .dma_rsp_o(dma_rsp_o),
		.cpu_gnt_o(cpu_gnt_o), .dma_gnt_o(dma_gnt_o),
		.bus_o(bus_o), .dev_stb_o(dev_stb_o), .dev_rsp_i(dev_rsp),
		.sd_req_i(sd_req), .sd_lines_i(sd_lines), .sd_ack_o(sd_ack_o),
		.sdcard_cs_o(sdcard_cs_o), .sdcard_mosi_o(sdcard_mosi_o)
	);

	//************************************************************
	//* reference functions
	//************************************************************
	function automatic logic in_window(input logic [16:0] adr, input logic [16:0] base,
		input int unsigned lsb);
		logic [16:0] mask;
		mask = {17{1'b1}} << lsb;  // compared bits 16..lsb
		return (adr & mask) == (base & mask);
	endfunction

	function automatic dev_sel_t decode_address(input logic [16:0] adr);
		dev_sel_t s;
		s = '0;
		s[DEV_UART1] = in_window(adr, `UART1_BASE, `UART1_LSB);
		s[DEV_UART2] = in_window(adr, `UART2_BASE, `UART2_LSB);
		s[DEV_LPT]   = in_window(adr, `LPT_BASE, `LPT_LSB);
		s[DEV_RK]    = in_window(adr, `RK_BASE, `RK_LSB);
		s[DEV_DW]    = in_window(adr, `DW_BASE, `DW_LSB);
		s[DEV_DX]    = in_window(adr, `DX_BASE, `DX_LSB);
		s[DEV_MY]    = in_window(adr, `MY_BASE, `MY_LSB);
		s[DEV_KGD]   = in_window(adr, `KGD_BASE, `KGD_LSB);
		s[DEV_ROM]   = adr[16:13] == 4'b1110;
		s[DEV_DRAM]  = (adr[15:13] != 3'b111) != adr[16];  // bit 16 flips the split
		return s;
	endfunction

	// read pattern from device index and whole address
	function automatic logic [15:0] device_data(input int unsigned d, input logic [16:0] adr);
		return {d[3:0], 12'h000} ^ adr[15:0] ^ {15'd0, adr[16]} ^ 16'h5a5a;
	endfunction

	// window bases and their edges, or a fully random address
	function automatic logic [16:0] pick_address();
		logic [16:0] base;
		int unsigned lsb;
		if ($urandom % 4 == 0) return 17'($urandom);
		case ($urandom % 10)
			0: begin base = `UART1_BASE; lsb = `UART1_LSB; end
			1: begin base = `UART2_BASE; lsb = `UART2_LSB; end
			2: begin base = `LPT_BASE; lsb = `LPT_LSB; end
			3: begin base = `RK_BASE; lsb = `RK_LSB; end
			4: begin base = `DW_BASE; lsb = `DW_LSB; end
			5: begin base = `DX_BASE; lsb = `DX_LSB; end
			6: begin base = `MY_BASE; lsb = `MY_LSB; end
			7: begin base = `KGD_BASE; lsb = `KGD_LSB; end
			8: begin base = 17'o160000; lsb = 13; end  // DRAM top in user mode
			default: begin base = 17'o340000; lsb = 13; end  // ROM shadow
		endcase
		case ($urandom % 4)
			0: return base;
			1: return base - 17'd2;
			2: return base + (17'd1 << lsb) - 17'd2;
			default: return base + (17'd1 << lsb);
		endcase
	endfunction

	function automatic wb_req_t new_request();
		wb_req_t r;
		r.adr = pick_address();
		r.dat = 16'($urandom);
		r.we  = 1'($urandom);
		r.sel = 2'($urandom);
		r.cyc = 1'b1;
		r.stb = 1'b1;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("Error %0t: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	//************************************************************
	//* stimulus and models
	//************************************************************
	always_comb begin
		exp_bus = cpu_req;  // CPU unless a DMA grant
		for (int i = 0; i < `DMA_MASTERS; i++) begin
			if (model_gnt[i]) begin
				exp_bus = dma_req[i];
				exp_bus.adr[16] = 1'b0;
				exp_bus.sel = 2'b11;
			end
		end
	end

	always @(posedge wb_clk) begin
		wb_req_t cur, nxt;
		logic ack, granted, unmapped;
		int unsigned fin, r;
		fin = 0;
		unmapped = (decode_address(exp_bus.adr) == '0);  // no device will ever answer
		for (int m = 0; m <= `DMA_MASTERS; m++) begin
			cur = (m == 0) ? cpu_req : dma_req[m-1];
			ack = (m == 0) ? cpu_rsp_o.ack : dma_rsp_o[m-1].ack;
			granted = (m == 0) ? (model_gnt == '0) : model_gnt[m-1];
			nxt = cur;
			if (rst_i) nxt = '0;
			else if (cur.cyc && (ack || (granted && unmapped))) begin
				nxt.cyc = 1'b0;  // transfer done or bus error on an empty address
				nxt.stb = 1'b0;
				fin++;
			end else if (!cur.cyc && (m == 0 || $urandom % 8 == 0)) nxt = new_request();
			if (m == 0) cpu_req <= nxt;
			else dma_req[m-1] <= nxt;
		end
		txn_done <= txn_done + fin;
		// grant model only switches on an idle bus
		if (rst_i) model_gnt <= '0;
		else if (!exp_bus.cyc) model_gnt <= dma_req[0].cyc ? 2'b01 : {dma_req[1].cyc, 1'b0};
		// devices answer 1 to 4 edges after the strobe
		for (int d = 0; d < DEV_NUM; d++) begin
			r = $urandom % 4;
			if (rst_i || dev_rsp[d].ack || !dev_stb_o[d]) begin
				dev_rsp[d] <= '{dat: 16'($urandom), ack: 1'b0};  // junk when idle
				dev_busy[d] <= 1'b0;
			end else if ((!dev_busy[d] && r == 0) || (dev_busy[d] && dev_cnt[d] == 0)) begin
				dev_rsp[d] <= '{dat: device_data(d, bus_o.adr), ack: 1'b1};
			end else begin
				dev_busy[d] <= 1'b1;
				dev_cnt[d] <= dev_busy[d] ? dev_cnt[d] - 1 : r - 1;
			end
		end
		// SD ports and ownership model
		for (int p = 0; p < `SD_PORTS; p++) begin
			sd_lines[p] <= 2'($urandom);
			if (model_own[p]) sd_req[p] <= ($urandom % 8 != 0);  // holder lets go now and then
			else sd_req[p] <= ($urandom % 4 == 0);
		end
		if (rst_i) model_own <= '0;
		else if (model_own == '0) model_own <= sd_req & (~sd_req + 1'b1);  // lowest request
		else if ((model_own & ~sd_req) != '0) model_own <= '0;  // holder dropped its request
	end

	//************************************************************
	//* checks on the falling edge
	//************************************************************
	always @(negedge wb_clk) begin
		dev_sel_t exp_stb;
		wb_rsp_t exp_rsp;
		sd_lines_t exp_lines;
		if (!rst_i) begin
			exp_stb = (exp_bus.cyc && exp_bus.stb) ? decode_address(exp_bus.adr) : '0;
			exp_rsp = '0;
			for (int d = 0; d < DEV_NUM; d++) begin
				exp_rsp.ack |= dev_rsp[d].ack;
				if (exp_stb[d]) exp_rsp.dat = dev_rsp[d].dat;
			end
			check_value("dma_gnt_o", dma_gnt_o, model_gnt);
			check_value("cpu_gnt_o", cpu_gnt_o, model_gnt == '0);
			check_value("bus_o", bus_o, exp_bus);
			check_value("dev_stb_o", dev_stb_o, exp_stb);
			check_value("dev_stb_o one-hot", $onehot0(dev_stb_o), 1'b1);
			check_value("cpu_rsp_o.ack", cpu_rsp_o.ack, exp_rsp.ack && model_gnt == '0);
			if (model_gnt == '0) check_value("cpu_rsp_o.dat", cpu_rsp_o.dat, exp_rsp.dat);
			for (int i = 0; i < `DMA_MASTERS; i++) begin
				check_value("dma_rsp_o.ack", dma_rsp_o[i].ack, exp_rsp.ack && model_gnt[i]);
				if (model_gnt[i]) check_value("dma_rsp_o.dat", dma_rsp_o[i].dat, exp_rsp.dat);
			end
			exp_lines = sd_lines[0];  // port 0 when the card is idle
			for (int p = 1; p < `SD_PORTS; p++) begin
				if (model_own[p]) exp_lines = sd_lines[p];
			end
			check_value("sd_ack_o", sd_ack_o, model_own);
			check_value("sdcard_cs_o", sdcard_cs_o, exp_lines.cs);
			check_value("sdcard_mosi_o", sdcard_mosi_o, exp_lines.mosi);
		end
	end

	//************************************************************
	//* run control
	//************************************************************
	initial begin
		void'($urandom(32'h93941340));
		cpu_req = '0;
		sd_req = '0;
		model_gnt = '0;
		model_own = '0;
		txn_done = 0;
		cycles = 0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < `DMA_MASTERS; i++) dma_req[i] = '0;
		for (int p = 0; p < `SD_PORTS; p++) sd_lines[p] = '0;
		for (int d = 0; d < DEV_NUM; d++) begin
			dev_rsp[d] = '0;
			dev_busy[d] = 1'b0;
			dev_cnt[d] = 0;
		end
		@(negedge rst_i);
		@(negedge wb_clk);
		// state straight out of reset
		check_value("cpu_gnt_o", cpu_gnt_o, 1'b1);
		check_value("dma_gnt_o", dma_gnt_o, '0);
		check_value("sd_ack_o", sd_ack_o, '0);
		while (txn_done < NUM_TXN && cycles < CYCLE_LIMIT) begin
			@(posedge wb_clk);
			cycles++;
		end
		if (txn_done < NUM_TXN) begin
			$display("Timeout after %0d cycles with %0d transfers done", cycles, txn_done);
			errors++;
		end
		$display("checks %0d, errors %0d, transfers %0d", checks, errors, txn_done);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/board_pkg.sv
verilog/bus_master_arbiter.sv
verilog/io_page_decoder.sv
verilog/slave_response_mux.sv
verilog/sd_card_dispatcher.sv
verilog/mc1201_fabric.sv
tb/tb_clock.sv
tb/tb_mc1201_fabric.sv

/* Makefile */
# Verilator build for the MC1201 bus fabric

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_mc1201_fabric
RTL_TOP   ?= mc1201_fabric
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

lint-rtl:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

.PHONY: lint-rtl
